// ==== logic/bp_pkg.sv ====
package bp_pkg;

	localparam int PC_W = 64;
	localparam int RFIFO_AW = 4;                   // resolve queue holds 2^RFIFO_AW branches
	localparam int RAS_AW = 4;                     // return stack holds 2^RAS_AW addresses
	localparam int RFIFO_DEPTH = 1 << RFIFO_AW;
	localparam int RAS_DEPTH = 1 << RAS_AW;

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [RFIFO_AW-1:0] rfifo_addr_t;     // slot index inside the resolve queue
	typedef logic [RFIFO_AW:0] rfifo_ptr_t;        // extra msb tells full from empty
	typedef logic [RAS_AW-1:0] ras_ptr_t;          // slot index inside the return stack
	typedef logic [RAS_AW:0] ras_cnt_t;            // occupancy saturates at RAS_DEPTH

	localparam pc_t BOOT_PC = 64'h0000_0000_8000_0000;

	typedef struct packed {
		logic is_jal;
		logic is_jalr;
		logic is_branch;
		logic is_call;
		logic is_return;
		logic is_rvc;                              // compressed encoding is 2 bytes long
		pc_t imm;                                  // sign-extended offset
	} instr_info_t;

	typedef struct packed {
		logic taken;                               // the static prediction that was followed
		pc_t alt_pc;                               // where fetch goes if the prediction is wrong
	} resolve_t;

	typedef struct packed {
		logic valid;
		pc_t target;
	} jalr_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} bru_t;

endpackage

// ==== logic/resolve_fifo.sv ====
`timescale 1ns/1ps

module resolve_fifo (
	input logic CLK,
	input logic rst,
	input logic push,
	input logic pop,
	input logic flush,
	input bp_pkg::resolve_t push_data,
	output bp_pkg::resolve_t pop_data,
	output logic full
);

	bp_pkg::resolve_t mem [bp_pkg::RFIFO_DEPTH];

	bp_pkg::rfifo_ptr_t wr_ptr;
	bp_pkg::rfifo_ptr_t rd_ptr;
	bp_pkg::rfifo_addr_t wr_addr;
	bp_pkg::rfifo_addr_t rd_addr;
	logic empty;
	logic do_push;
	logic do_pop;

	assign wr_addr = wr_ptr[bp_pkg::RFIFO_AW-1:0];
	assign rd_addr = rd_ptr[bp_pkg::RFIFO_AW-1:0];

	// same slot with the wrap bits apart means the writer lapped the reader
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_addr == rd_addr) &&
		(wr_ptr[bp_pkg::RFIFO_AW] != rd_ptr[bp_pkg::RFIFO_AW]);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign pop_data = empty ? '0 : mem[rd_addr];   // oldest unresolved branch

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;                          // a redirect drops every outstanding branch
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + bp_pkg::rfifo_ptr_t'(1);
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + bp_pkg::rfifo_ptr_t'(1);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_addr] <= push_data;
		end
	end

	// the branch unit only reports results for branches that were queued
	a_pop_not_empty: assert property (
		@(posedge CLK) disable iff (rst)
		pop |-> !empty
	) else $error("resolve_fifo: pop while empty");

	// the predictor has to stall a branch while the queue is full
	a_push_not_full: assert property (
		@(posedge CLK) disable iff (rst)
		push |-> !full
	) else $error("resolve_fifo: push while full");

endmodule

// ==== logic/return_stack.sv ====
`timescale 1ns/1ps

module return_stack (
	input logic CLK,
	input logic rst,
	input logic push,
	input logic pop,
	input logic flush,
	input bp_pkg::pc_t push_addr,
	output bp_pkg::pc_t top_addr,
	output logic empty
);

	bp_pkg::pc_t mem [bp_pkg::RAS_DEPTH];

	bp_pkg::ras_ptr_t top;                         // slot of the most recent return address
	bp_pkg::ras_ptr_t wr_slot;
	bp_pkg::ras_cnt_t count;
	logic full;
	logic wr_en;

	assign empty = (count == '0);
	assign full = (count == bp_pkg::ras_cnt_t'(bp_pkg::RAS_DEPTH));

	// push with pop reuses the top slot while a lone push moves one slot up and may wrap
	assign wr_slot = pop ? top : top + bp_pkg::ras_ptr_t'(1);
	assign wr_en = push && !flush;

	assign top_addr = empty ? '0 : mem[top];

	always_ff @(posedge CLK) begin
		if (rst) begin
			top <= '0;
			count <= '0;
		end else if (flush) begin
			top <= '0;
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: begin
					top <= wr_slot;
					if (!full) begin
						count <= count + bp_pkg::ras_cnt_t'(1);
					end
					// when full the oldest return address is lost under the new one
				end
				2'b01: begin
					if (!empty) begin
						top <= top - bp_pkg::ras_ptr_t'(1);
						count <= count - bp_pkg::ras_cnt_t'(1);
					end
				end
				default: begin
					// idle or a call-return that swaps the top entry in place
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_slot] <= push_addr;
		end
	end

	// the predictor pops only for a return that it served from this stack
	a_pop_not_empty: assert property (
		@(posedge CLK) disable iff (rst)
		pop |-> !empty
	) else $error("return_stack: pop while empty");

endmodule

// ==== logic/branch_predict.sv ====
`timescale 1ns/1ps

module branch_predict (
	input logic CLK,
	input logic rst,
	input bp_pkg::pc_t fetch_pc,
	input bp_pkg::instr_info_t instr_info,
	input bp_pkg::jalr_t jalr,
	input bp_pkg::bru_t bru,
	input logic exception,
	input bp_pkg::pc_t exception_pc,
	input logic instr_fifo_full,
	input logic fetch_buff_ready,
	output bp_pkg::pc_t next_pc,
	output logic fetch_valid,
	output logic mispredict
);

	bp_pkg::pc_t seq_pc;
	bp_pkg::pc_t taken_pc;
	bp_pkg::pc_t ras_top;
	bp_pkg::resolve_t rf_push_data;
	bp_pkg::resolve_t rf_pop_data;

	logic taken;
	logic ras_hit;
	logic ras_empty;
	logic ras_push;
	logic ras_pop;
	logic rf_full;
	logic rf_push;
	logic rf_pop;
	logic flush;
	logic jalr_stall;
	logic branch_stall;

	assign seq_pc = fetch_pc + (instr_info.is_rvc ? bp_pkg::pc_t'(2) : bp_pkg::pc_t'(4));

	// jumps are always taken, backward branches are not and forward ones are
	assign taken = instr_info.is_jal || instr_info.is_jalr ||
		(instr_info.is_branch && !instr_info.imm[bp_pkg::PC_W-1]);

	// a return can go ahead on the stack top before the register value arrives
	assign ras_hit = instr_info.is_jalr && instr_info.is_return && !ras_empty;

	always_comb begin
		if (instr_info.is_jal || instr_info.is_branch) begin
			taken_pc = fetch_pc + instr_info.imm;
		end else if (ras_hit) begin
			taken_pc = ras_top;
		end else begin
			taken_pc = jalr.target;
		end
	end

	assign jalr_stall = instr_info.is_jalr && !jalr.valid && !ras_hit;
	assign branch_stall = instr_info.is_branch && rf_full;

	assign mispredict = bru.valid && (bru.taken != rf_pop_data.taken);
	assign flush = mispredict || exception;

	// a redirect always moves the PC even past a stall or back-pressure
	assign fetch_valid = (!jalr_stall && !branch_stall && !instr_fifo_full && fetch_buff_ready) ||
		mispredict || exception;

	always_comb begin
		if (exception) begin
			next_pc = exception_pc;
		end else if (mispredict) begin
			next_pc = rf_pop_data.alt_pc;
		end else if (jalr_stall || branch_stall) begin
			next_pc = fetch_pc;
		end else if (taken) begin
			next_pc = taken_pc;
		end else begin
			next_pc = seq_pc;
		end
	end

	assign rf_push_data.taken = taken;
	assign rf_push_data.alt_pc = taken ? seq_pc : taken_pc;    // the path not followed
	assign rf_push = instr_info.is_branch && !rf_full && fetch_valid;
	assign rf_pop = bru.valid;

	assign ras_push = instr_info.is_call && (instr_info.is_jal || instr_info.is_jalr) && fetch_valid;
	assign ras_pop = ras_hit && fetch_valid;

	resolve_fifo u_resolve_fifo (
		.CLK(CLK),
		.rst(rst),
		.push(rf_push),
		.pop(rf_pop),
		.flush(flush),
		.push_data(rf_push_data),
		.pop_data(rf_pop_data),
		.full(rf_full)
	);

	return_stack u_return_stack (
		.CLK(CLK),
		.rst(rst),
		.push(ras_push),
		.pop(ras_pop),
		.flush(flush),
		.push_addr(seq_pc),                       // return lands right after the call
		.top_addr(ras_top),
		.empty(ras_empty)
	);

endmodule

// ==== logic/pcgen_unit.sv ====
`timescale 1ns/1ps

module pcgen_unit (
	input logic CLK,
	input logic rst,
	input bp_pkg::instr_info_t instr_info,
	input bp_pkg::jalr_t jalr,
	input bp_pkg::bru_t bru,
	input logic exception,
	input bp_pkg::pc_t exception_pc,
	input logic instr_fifo_full,
	input logic fetch_buff_ready,
	output bp_pkg::pc_t fetch_pc,
	output logic fetch_valid,
	output logic mispredict
);

	bp_pkg::pc_t next_pc;
	bp_pkg::pc_t pc_q;

	assign fetch_pc = pc_q;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc_q <= bp_pkg::BOOT_PC;
		end else if (fetch_valid) begin
			pc_q <= next_pc;                       // hold under back-pressure or a stall
		end
	end

	branch_predict u_branch_predict (
		.CLK(CLK),
		.rst(rst),
		.fetch_pc(pc_q),
		.instr_info(instr_info),
		.jalr(jalr),
		.bru(bru),
		.exception(exception),
		.exception_pc(exception_pc),
		.instr_fifo_full(instr_fifo_full),
		.fetch_buff_ready(fetch_buff_ready),
		.next_pc(next_pc),
		.fetch_valid(fetch_valid),
		.mispredict(mispredict)
	);

endmodule

// ==== testbench/pcgen_unit_tb.sv ====
`timescale 1ns/1ps

module pcgen_unit_tb;

	localparam int NUM_CYCLES = 3000;
	localparam int CLK_PERIOD = 4;

	logic CLK;
	logic rst;
	bp_pkg::instr_info_t instr_info;
	bp_pkg::jalr_t jalr;
	bp_pkg::bru_t bru;
	logic exception;
	bp_pkg::pc_t exception_pc;
	logic instr_fifo_full;
	logic fetch_buff_ready;
	bp_pkg::pc_t fetch_pc;
	logic fetch_valid;
	logic mispredict;

	logic [31:0] lfsr_state;
	bp_pkg::pc_t m_pc;                             // model of the fetch PC register
	bp_pkg::resolve_t rq[$];                       // model resolve queue with the oldest at index 0
	bp_pkg::pc_t ras[$];                           // model return stack with its top at the back

	pcgen_unit u_pcgen_unit (
		.CLK(CLK),
		.rst(rst),
		.instr_info(instr_info),
		.jalr(jalr),
		.bru(bru),
		.exception(exception),
		.exception_pc(exception_pc),
		.instr_fifo_full(instr_fifo_full),
		.fetch_buff_ready(fetch_buff_ready),
		.fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid),
		.mispredict(mispredict)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			$display("Something failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// compares the outputs of this cycle, then moves the model across the coming edge
	task automatic check_and_step();
		bp_pkg::pc_t seq;
		bp_pkg::pc_t target;
		bp_pkg::pc_t nxt;
		bp_pkg::resolve_t head;
		bp_pkg::resolve_t entry;
		logic taken;
		logic ras_hit;
		logic stall;
		logic misp;
		logic fv;
		seq = m_pc + (instr_info.is_rvc ? bp_pkg::pc_t'(2) : bp_pkg::pc_t'(4));
		taken = instr_info.is_jal || instr_info.is_jalr ||
			(instr_info.is_branch && !instr_info.imm[63]);
		ras_hit = instr_info.is_jalr && instr_info.is_return && (ras.size() > 0);
		if (instr_info.is_jal || instr_info.is_branch) begin
			target = m_pc + instr_info.imm;
		end else if (ras_hit) begin
			target = ras[$];
		end else begin
			target = jalr.target;
		end
		stall = (instr_info.is_jalr && !jalr.valid && !ras_hit) ||
			(instr_info.is_branch && rq.size() == 16);
		head = '0;
		if (rq.size() > 0) begin
			head = rq[0];
		end
		misp = bru.valid && (bru.taken != head.taken);
		fv = (!stall && !instr_fifo_full && fetch_buff_ready) || misp || exception;
		if (exception) nxt = exception_pc;
		else if (misp) nxt = head.alt_pc;
		else if (stall) nxt = m_pc;
		else nxt = taken ? target : seq;

		check_value("fetch_pc", fetch_pc, m_pc);
		check_value("fetch_valid", 64'(fetch_valid), 64'(fv));
		check_value("mispredict", 64'(mispredict), 64'(misp));

		if (fv) m_pc = nxt;
		if (misp || exception) begin
			rq.delete();                           // redirect drops all speculation
			ras.delete();
		end else begin
			if (bru.valid) rq.delete(0);
			if (instr_info.is_branch && !stall && fv) begin
				entry.taken = taken;
				entry.alt_pc = taken ? seq : target;
				rq.push_back(entry);
			end
			if (ras_hit && fv) ras.delete(ras.size() - 1);
			if (instr_info.is_call && (instr_info.is_jal || instr_info.is_jalr) && fv) begin
				ras.push_back(seq);
				if (ras.size() > 16) ras.delete(0);    // oldest call is lost
			end
		end
	endtask

	task automatic drive_random(input int cycle);
		logic [31:0] r;
		logic quiet;
		bp_pkg::instr_info_t info;
		bp_pkg::jalr_t jv;
		bp_pkg::bru_t b;
		bp_pkg::pc_t off;
		quiet = ((cycle / 256) % 2) == 1;          // no results and no exceptions let the queues fill
		info = '0;
		r = take_bits(4);
		case (r[3:0])
			4'd6, 4'd7, 4'd8: info.is_branch = 1'b1;
			4'd9: info.is_jal = 1'b1;
			4'd10, 4'd12: begin
				info.is_jal = 1'b1;
				info.is_call = 1'b1;
			end
			4'd11: begin
				info.is_jalr = 1'b1;
				info.is_call = 1'b1;
			end
			4'd13: begin
				info.is_jalr = 1'b1;
				info.is_return = 1'b1;
			end
			4'd14: info.is_jalr = 1'b1;
			default: begin
				// plain sequential instruction
			end
		endcase
		r = take_bits(1);
		info.is_rvc = r[0];
		r = take_bits(6);
		off = bp_pkg::pc_t'({r[5:0], 1'b0}) + bp_pkg::pc_t'(2);
		r = take_bits(1);
		info.imm = r[0] ? -off : off;
		r = take_bits(1);
		jv.valid = r[0];
		r = take_bits(8);
		jv.target = bp_pkg::BOOT_PC + bp_pkg::pc_t'({r[7:0], 2'b00});
		b = '0;
		if (rq.size() > 0) begin
			r = take_bits(2);
			b.valid = !quiet && (r == 32'd0);
			r = take_bits(1);
			b.taken = r[0];
		end
		instr_info <= info;
		jalr <= jv;
		bru <= b;
		r = take_bits(3);
		instr_fifo_full <= (r[2:0] == 3'd0);
		r = take_bits(3);
		fetch_buff_ready <= (r[2:0] != 3'd0);
		r = quiet ? 32'd1 : take_bits(6);
		exception <= (r == 32'd0);
		r = take_bits(8);
		exception_pc <= bp_pkg::BOOT_PC + bp_pkg::pc_t'(32'h1000) +
			bp_pkg::pc_t'({r[7:0], 2'b00});
	endtask

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(2 * NUM_CYCLES * CLK_PERIOD);
		$display("timeout: the test did not reach its last cycle in time");
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int cycle;
		lfsr_state = 32'h2caa;
		rst = 1'b1;
		instr_info = '0;
		jalr = '0;
		bru = '0;
		exception = 1'b0;
		exception_pc = '0;
		instr_fifo_full = 1'b0;
		fetch_buff_ready = 1'b0;
		m_pc = bp_pkg::BOOT_PC;
		repeat (2) @(posedge CLK);
		rst <= 1'b0;
		for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
			@(negedge CLK);                        // outputs are settled half a period after the edge
			check_and_step();
			@(posedge CLK);
			drive_random(cycle);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/bp_pkg.sv
logic/resolve_fifo.sv
logic/return_stack.sv
logic/branch_predict.sv
logic/pcgen_unit.sv
testbench/pcgen_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= verilog.f
TB_TOP ?= pcgen_unit_tb
RTL_TOP ?= pcgen_unit
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= Everything OK

RTL_FILES := $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
